// ==== design/nbc_pkg.sv ====
// non-blocking cache tag-lookup shared definitions
// fixed geometry, memory opcodes and the address word layout
package nbc_pkg;

  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int id_width = 4;
  localparam int ways = 4;
  localparam int lg_ways = 2;
  localparam int sets = 16;
  localparam int lg_sets = 4;
  localparam int block_words = 4;
  localparam int lg_block_words = 2;
  localparam int byte_sel_width = 2;
  localparam int block_offset_width = byte_sel_width + lg_block_words;
  localparam int tag_width = addr_width - lg_sets - block_offset_width;

  // tag store data word, tag in the low bits
  localparam int tagst_valid_bit = 31;
  localparam int tagst_lock_bit = 30;

  typedef enum logic {
    tag_read,
    tag_store
  } tag_op_e;

  typedef enum logic {
    stat_set_lru,
    stat_set_lru_and_dirty
  } stat_op_e;

  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [lg_sets-1:0] index;
    logic [lg_block_words-1:0] word;
    logic [byte_sel_width-1:0] byte_sel;
  } addr_acc_s;

  // management ops put the way just above the index
  typedef struct packed {
    logic [tag_width-lg_ways-1:0] upper;
    logic [lg_ways-1:0] way;
    logic [lg_sets-1:0] index;
    logic [block_offset_width-1:0] offset;
  } addr_mgmt_s;

  typedef union packed {
    addr_acc_s acc;
    addr_mgmt_s mgmt;
  } nbc_addr_u;

endpackage

// ==== design/nbc_tag_mem.sv ====
`timescale 1ns/100ps
// tag, valid and lock storage for every way of each set
// a read returns the whole set one cycle later, a store writes one way
module nbc_tag_mem (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  nbc_pkg::tag_op_e opcode_i,
  input  logic [nbc_pkg::lg_sets-1:0] index_i,
  input  logic [nbc_pkg::lg_ways-1:0] way_i,
  input  logic [nbc_pkg::data_width-1:0] data_i,
  output logic [nbc_pkg::ways-1:0] valid_o,
  output logic [nbc_pkg::ways-1:0] lock_o,
  output logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_o
);

  logic [nbc_pkg::ways-1:0] valid_r [nbc_pkg::sets];
  logic [nbc_pkg::ways-1:0] lock_r [nbc_pkg::sets];
  logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_r [nbc_pkg::sets];

  logic rd_en;
  logic wr_en;

  assign rd_en = v_i & (opcode_i == nbc_pkg::tag_read);
  assign wr_en = v_i & (opcode_i == nbc_pkg::tag_store);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < nbc_pkg::sets; s++) begin
        valid_r[s] <= '0;
      end
    end else if (wr_en) begin
      valid_r[index_i][way_i] <= data_i[nbc_pkg::tagst_valid_bit];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      lock_r[index_i][way_i] <= data_i[nbc_pkg::tagst_lock_bit];
      tag_r[index_i][way_i] <= data_i[nbc_pkg::tag_width-1:0];
    end
  end

  // registered set read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= '0;
    end else if (rd_en) begin
      valid_o <= valid_r[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      lock_o <= lock_r[index_i];
      tag_o <= tag_r[index_i];
    end
  end

endmodule

// ==== design/nbc_tl_stage.sv ====
`timescale 1ns/100ps
// tag-lookup stage that holds one request, checks its set for a hit and
// sends it to the data/stat memories, the miss queue or the management path
module nbc_tl_stage (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic [nbc_pkg::id_width-1:0] id_i,
  input  logic [nbc_pkg::addr_width-1:0] addr_i,
  input  logic [nbc_pkg::data_width-1:0] data_i,
  input  logic ld_op_i,
  input  logic st_op_i,
  input  logic block_ld_op_i,
  input  logic mgmt_op_i,
  input  logic tagst_op_i,
  input  logic [nbc_pkg::byte_sel_width-1:0] size_op_i,
  output logic ready_o,
  output logic data_mem_pkt_v_o,
  output logic data_mem_write_not_read_o,
  output logic [nbc_pkg::byte_sel_width-1:0] data_mem_size_op_o,
  output logic [nbc_pkg::byte_sel_width-1:0] data_mem_byte_sel_o,
  output logic [nbc_pkg::lg_ways-1:0] data_mem_way_o,
  output logic [nbc_pkg::lg_sets+nbc_pkg::lg_block_words-1:0] data_mem_addr_o,
  output logic [nbc_pkg::data_width-1:0] data_mem_data_o,
  output logic stat_mem_pkt_v_o,
  output logic [nbc_pkg::lg_ways-1:0] stat_mem_way_o,
  output logic [nbc_pkg::lg_sets-1:0] stat_mem_index_o,
  output nbc_pkg::stat_op_e stat_mem_opcode_o,
  input  logic data_mem_ready_i,
  input  logic stat_mem_ready_i,
  output logic block_loading_o,
  output logic miss_v_o,
  output logic miss_write_not_read_o,
  output logic miss_block_load_o,
  output logic [nbc_pkg::byte_sel_width-1:0] miss_size_op_o,
  output logic [nbc_pkg::id_width-1:0] miss_id_o,
  output logic [nbc_pkg::addr_width-1:0] miss_addr_o,
  output logic [nbc_pkg::data_width-1:0] miss_data_o,
  input  logic miss_ready_i,
  output logic mgmt_v_o,
  output logic [nbc_pkg::ways-1:0] valid_tl_o,
  output logic [nbc_pkg::ways-1:0] lock_tl_o,
  output logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_tl_o,
  output logic [nbc_pkg::lg_ways-1:0] tag_hit_way_o,
  output logic tag_hit_found_o,
  input  logic mgmt_yumi_i,
  input  logic mhu_tag_v_i,
  input  nbc_pkg::tag_op_e mhu_tag_opcode_i,
  input  logic [nbc_pkg::lg_sets-1:0] mhu_tag_index_i,
  input  logic [nbc_pkg::lg_ways-1:0] mhu_tag_way_i,
  input  logic [nbc_pkg::data_width-1:0] mhu_tag_data_i,
  input  logic mhu_idle_i,
  input  logic recover_i,
  input  logic evict_v_i,
  input  logic [nbc_pkg::addr_width-1:0] evict_addr_i
);

  nbc_pkg::nbc_addr_u addr_in;
  nbc_pkg::nbc_addr_u addr_tl_r;

  logic v_tl_r;
  logic v_tl_n;
  logic block_mode_r;
  logic block_mode_n;
  logic tl_we;
  logic ld_tl_r;
  logic st_tl_r;
  logic block_ld_tl_r;
  logic mgmt_tl_r;
  logic [nbc_pkg::byte_sel_width-1:0] size_tl_r;
  logic [nbc_pkg::id_width-1:0] id_tl_r;
  logic [nbc_pkg::data_width-1:0] data_tl_r;

  logic [nbc_pkg::lg_block_words-1:0] counter_r;
  logic counter_up;
  logic counter_clear;
  logic counter_max;

  logic tag_v;
  nbc_pkg::tag_op_e tag_op;
  logic [nbc_pkg::lg_sets-1:0] tag_index;
  logic [nbc_pkg::lg_ways-1:0] tag_way;
  logic [nbc_pkg::data_width-1:0] tag_data;
  logic [nbc_pkg::ways-1:0] valid_tl;
  logic [nbc_pkg::ways-1:0] lock_tl;
  logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_tl;

  logic [nbc_pkg::lg_ways-1:0] tag_hit_way;
  logic tag_hit_found;
  logic [nbc_pkg::addr_width-1:0] block_addr_tl;
  logic miss_tl;
  logic ld_st_hit;
  logic block_ld_hit;
  logic ld_st_miss;
  logic mgmt_op_tl;
  logic ld_st_ready;
  logic take_lookup;
  logic block_done;

  assign addr_in = addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      block_mode_r <= 1'b0;
      counter_r <= '0;
    end else begin
      v_tl_r <= v_tl_n;
      block_mode_r <= block_mode_n;
      if (counter_clear) begin
        counter_r <= '0;
      end else if (counter_up) begin
        counter_r <= counter_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      ld_tl_r <= ld_op_i;
      st_tl_r <= st_op_i;
      block_ld_tl_r <= block_ld_op_i;
      mgmt_tl_r <= mgmt_op_i;
      size_tl_r <= size_op_i;
      id_tl_r <= id_i;
      addr_tl_r <= addr_in;
      data_tl_r <= data_i;
    end
  end

  assign counter_max = counter_r == (nbc_pkg::block_words - 1);
  assign block_loading_o = block_mode_r;

  nbc_tag_mem i_tag_mem (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(tag_v),
    .opcode_i(tag_op),
    .index_i(tag_index),
    .way_i(tag_way),
    .data_i(tag_data),
    .valid_o(valid_tl),
    .lock_o(lock_tl),
    .tag_o(tag_tl)
  );

  // lowest valid matching way wins
  always_comb begin
    tag_hit_way = '0;
    tag_hit_found = 1'b0;
    for (int i = nbc_pkg::ways - 1; i >= 0; i--) begin
      if (valid_tl[i] && (tag_tl[i] == addr_tl_r.acc.tag)) begin
        tag_hit_way = i[nbc_pkg::lg_ways-1:0];
        tag_hit_found = 1'b1;
      end
    end
  end

  // block being evicted counts as a miss
  assign block_addr_tl = {addr_tl_r.acc.tag, addr_tl_r.acc.index,
                          {nbc_pkg::block_offset_width{1'b0}}};
  assign miss_tl = ~tag_hit_found | (evict_v_i & (evict_addr_i == block_addr_tl));

  assign ld_st_hit = v_tl_r & (ld_tl_r | st_tl_r) & ~miss_tl;
  assign block_ld_hit = v_tl_r & block_ld_tl_r & ~miss_tl;
  assign ld_st_miss = v_tl_r & (ld_tl_r | st_tl_r | block_ld_tl_r) & miss_tl;
  assign mgmt_op_tl = v_tl_r & mgmt_tl_r;
  assign ld_st_ready = data_mem_ready_i & stat_mem_ready_i;
  assign take_lookup = v_i & ~mgmt_op_i;
  assign block_done = ld_st_ready & counter_max;

  assign data_mem_write_not_read_o = st_tl_r;
  assign data_mem_size_op_o = size_tl_r;
  assign data_mem_byte_sel_o = addr_tl_r.acc.byte_sel;
  assign data_mem_way_o = tag_hit_way;
  assign data_mem_addr_o = block_ld_tl_r
    ? {addr_tl_r.acc.index, counter_r}
    : {addr_tl_r.acc.index, addr_tl_r.acc.word};
  assign data_mem_data_o = data_tl_r;

  assign stat_mem_way_o = tag_hit_way;
  assign stat_mem_index_o = addr_tl_r.acc.index;
  assign stat_mem_opcode_o = st_tl_r ? nbc_pkg::stat_set_lru_and_dirty : nbc_pkg::stat_set_lru;

  assign miss_write_not_read_o = st_tl_r;
  assign miss_block_load_o = block_ld_tl_r;
  assign miss_size_op_o = size_tl_r;
  assign miss_id_o = id_tl_r;
  assign miss_addr_o = addr_tl_r;
  assign miss_data_o = data_tl_r;

  assign valid_tl_o = valid_tl;
  assign lock_tl_o = lock_tl;
  assign tag_tl_o = tag_tl;
  assign tag_hit_way_o = tag_hit_way;
  assign tag_hit_found_o = tag_hit_found;

  always_comb begin
    ready_o = 1'b0;
    data_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_v_o = 1'b0;
    miss_v_o = 1'b0;
    mgmt_v_o = 1'b0;
    v_tl_n = v_tl_r;
    tl_we = 1'b0;
    block_mode_n = block_mode_r;
    counter_up = 1'b0;
    counter_clear = 1'b0;
    if (recover_i | mhu_tag_v_i) begin
      // stall while the miss handler owns the tag memory
      ready_o = 1'b0;
    end else if (ld_st_hit) begin
      data_mem_pkt_v_o = ld_st_ready;
      stat_mem_pkt_v_o = ld_st_ready;
      ready_o = ld_st_ready & ~(v_i & mgmt_op_i);
      v_tl_n = ld_st_ready ? take_lookup : v_tl_r;
      tl_we = ld_st_ready & take_lookup;
    end else if (ld_st_miss) begin
      miss_v_o = 1'b1;
      ready_o = miss_ready_i & ~(v_i & mgmt_op_i);
      v_tl_n = miss_ready_i ? take_lookup : v_tl_r;
      tl_we = miss_ready_i & take_lookup;
    end else if (block_ld_hit) begin
      data_mem_pkt_v_o = ld_st_ready;
      stat_mem_pkt_v_o = ld_st_ready;
      ready_o = block_done & ~(v_i & mgmt_op_i);
      v_tl_n = block_done ? take_lookup : v_tl_r;
      tl_we = block_done & take_lookup;
      counter_up = ld_st_ready & ~counter_max;
      counter_clear = block_done;
      block_mode_n = ld_st_ready ? ~counter_max : block_mode_r;
    end else if (mgmt_op_tl) begin
      mgmt_v_o = 1'b1;
      ready_o = mgmt_yumi_i & (~mgmt_op_i | mhu_idle_i);
      v_tl_n = mgmt_yumi_i ? (v_i & ready_o) : v_tl_r;
      tl_we = v_i & ready_o;
    end else begin
      // management waits here for an idle miss handler
      ready_o = ~mgmt_op_i | mhu_idle_i;
      v_tl_n = v_i & ready_o;
      tl_we = v_i & ready_o;
    end
  end

  // tag memory source by priority of recover, miss handler and new request
  always_comb begin
    tag_v = tl_we;
    tag_op = (mgmt_op_i & tagst_op_i) ? nbc_pkg::tag_store : nbc_pkg::tag_read;
    tag_index = addr_in.mgmt.index;
    tag_way = addr_in.mgmt.way;
    tag_data = data_i;
    if (recover_i) begin
      tag_v = 1'b1;
      tag_op = nbc_pkg::tag_read;
      tag_index = addr_tl_r.acc.index;
    end else if (mhu_tag_v_i) begin
      tag_v = 1'b1;
      tag_op = mhu_tag_opcode_i;
      tag_index = mhu_tag_index_i;
      tag_way = mhu_tag_way_i;
      tag_data = mhu_tag_data_i;
    end
  end

endmodule

// ==== design/nbc_miss_fifo.sv ====
`timescale 1ns/100ps
// four-entry queue of missed requests for the miss handler
module nbc_miss_fifo (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic write_not_read_i,
  input  logic block_load_i,
  input  logic [nbc_pkg::byte_sel_width-1:0] size_op_i,
  input  logic [nbc_pkg::id_width-1:0] id_i,
  input  logic [nbc_pkg::addr_width-1:0] addr_i,
  input  logic [nbc_pkg::data_width-1:0] data_i,
  input  logic yumi_i,
  output logic ready_o,
  output logic v_o,
  output logic write_not_read_o,
  output logic block_load_o,
  output logic [nbc_pkg::byte_sel_width-1:0] size_op_o,
  output logic [nbc_pkg::id_width-1:0] id_o,
  output logic [nbc_pkg::addr_width-1:0] addr_o,
  output logic [nbc_pkg::data_width-1:0] data_o
);

  logic wnr_mem [4];
  logic block_load_mem [4];
  logic [nbc_pkg::byte_sel_width-1:0] size_op_mem [4];
  logic [nbc_pkg::id_width-1:0] id_mem [4];
  logic [nbc_pkg::addr_width-1:0] addr_mem [4];
  logic [nbc_pkg::data_width-1:0] data_mem [4];

  logic [1:0] wr_ptr_r;
  logic [1:0] rd_ptr_r;
  logic [2:0] count_r;
  logic wr_en;
  logic rd_en;

  assign ready_o = count_r != 3'd4;
  assign v_o = count_r != 3'd0;
  assign wr_en = v_i & ready_o;
  assign rd_en = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      wr_ptr_r <= wr_ptr_r + {1'b0, wr_en};
      rd_ptr_r <= rd_ptr_r + {1'b0, rd_en};
      count_r <= count_r + {2'b0, wr_en} - {2'b0, rd_en};
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      wnr_mem[wr_ptr_r] <= write_not_read_i;
      block_load_mem[wr_ptr_r] <= block_load_i;
      size_op_mem[wr_ptr_r] <= size_op_i;
      id_mem[wr_ptr_r] <= id_i;
      addr_mem[wr_ptr_r] <= addr_i;
      data_mem[wr_ptr_r] <= data_i;
    end
  end

  // head of queue
  assign write_not_read_o = wnr_mem[rd_ptr_r];
  assign block_load_o = block_load_mem[rd_ptr_r];
  assign size_op_o = size_op_mem[rd_ptr_r];
  assign id_o = id_mem[rd_ptr_r];
  assign addr_o = addr_mem[rd_ptr_r];
  assign data_o = data_mem[rd_ptr_r];

endmodule

// ==== design/nbc_cache_tl_top.sv ====
`timescale 1ns/100ps
// cache tag-lookup front end with its miss queue
module nbc_cache_tl_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic [nbc_pkg::id_width-1:0] id_i,
  input  logic [nbc_pkg::addr_width-1:0] addr_i,
  input  logic [nbc_pkg::data_width-1:0] data_i,
  input  logic ld_op_i,
  input  logic st_op_i,
  input  logic block_ld_op_i,
  input  logic mgmt_op_i,
  input  logic tagst_op_i,
  input  logic [nbc_pkg::byte_sel_width-1:0] size_op_i,
  output logic ready_o,
  output logic data_mem_pkt_v_o,
  output logic data_mem_write_not_read_o,
  output logic [nbc_pkg::byte_sel_width-1:0] data_mem_size_op_o,
  output logic [nbc_pkg::byte_sel_width-1:0] data_mem_byte_sel_o,
  output logic [nbc_pkg::lg_ways-1:0] data_mem_way_o,
  output logic [nbc_pkg::lg_sets+nbc_pkg::lg_block_words-1:0] data_mem_addr_o,
  output logic [nbc_pkg::data_width-1:0] data_mem_data_o,
  output logic stat_mem_pkt_v_o,
  output logic [nbc_pkg::lg_ways-1:0] stat_mem_way_o,
  output logic [nbc_pkg::lg_sets-1:0] stat_mem_index_o,
  output nbc_pkg::stat_op_e stat_mem_opcode_o,
  input  logic data_mem_ready_i,
  input  logic stat_mem_ready_i,
  output logic block_loading_o,
  output logic miss_v_o,
  output logic miss_write_not_read_o,
  output logic miss_block_load_o,
  output logic [nbc_pkg::byte_sel_width-1:0] miss_size_op_o,
  output logic [nbc_pkg::id_width-1:0] miss_id_o,
  output logic [nbc_pkg::addr_width-1:0] miss_addr_o,
  output logic [nbc_pkg::data_width-1:0] miss_data_o,
  input  logic miss_yumi_i,
  output logic mgmt_v_o,
  output logic [nbc_pkg::ways-1:0] valid_tl_o,
  output logic [nbc_pkg::ways-1:0] lock_tl_o,
  output logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_tl_o,
  output logic [nbc_pkg::lg_ways-1:0] tag_hit_way_o,
  output logic tag_hit_found_o,
  input  logic mgmt_yumi_i,
  input  logic mhu_tag_v_i,
  input  nbc_pkg::tag_op_e mhu_tag_opcode_i,
  input  logic [nbc_pkg::lg_sets-1:0] mhu_tag_index_i,
  input  logic [nbc_pkg::lg_ways-1:0] mhu_tag_way_i,
  input  logic [nbc_pkg::data_width-1:0] mhu_tag_data_i,
  input  logic mhu_idle_i,
  input  logic recover_i,
  input  logic evict_v_i,
  input  logic [nbc_pkg::addr_width-1:0] evict_addr_i
);

  // stage to queue
  logic tl_miss_v;
  logic tl_miss_ready;
  logic tl_miss_write_not_read;
  logic tl_miss_block_load;
  logic [nbc_pkg::byte_sel_width-1:0] tl_miss_size_op;
  logic [nbc_pkg::id_width-1:0] tl_miss_id;
  logic [nbc_pkg::addr_width-1:0] tl_miss_addr;
  logic [nbc_pkg::data_width-1:0] tl_miss_data;

  nbc_tl_stage i_tl_stage (
    .*,
    .miss_v_o(tl_miss_v),
    .miss_write_not_read_o(tl_miss_write_not_read),
    .miss_block_load_o(tl_miss_block_load),
    .miss_size_op_o(tl_miss_size_op),
    .miss_id_o(tl_miss_id),
    .miss_addr_o(tl_miss_addr),
    .miss_data_o(tl_miss_data),
    .miss_ready_i(tl_miss_ready)
  );

  nbc_miss_fifo i_miss_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(tl_miss_v),
    .write_not_read_i(tl_miss_write_not_read),
    .block_load_i(tl_miss_block_load),
    .size_op_i(tl_miss_size_op),
    .id_i(tl_miss_id),
    .addr_i(tl_miss_addr),
    .data_i(tl_miss_data),
    .yumi_i(miss_yumi_i),
    .ready_o(tl_miss_ready),
    .v_o(miss_v_o),
    .write_not_read_o(miss_write_not_read_o),
    .block_load_o(miss_block_load_o),
    .size_op_o(miss_size_op_o),
    .id_o(miss_id_o),
    .addr_o(miss_addr_o),
    .data_o(miss_data_o)
  );

endmodule

// ==== verification/nbc_checker.sv ====
`timescale 1ns/100ps
// watcher for the tag-lookup front end
// tracks accepted requests and compares every outgoing packet with the trace
module nbc_checker (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic [nbc_pkg::byte_sel_width-1:0] size_op_i,
  input  logic ready_o,
  input  logic data_mem_ready_i,
  input  logic data_mem_pkt_v_o,
  input  logic data_mem_write_not_read_o,
  input  logic [nbc_pkg::byte_sel_width-1:0] data_mem_size_op_o,
  input  logic [nbc_pkg::byte_sel_width-1:0] data_mem_byte_sel_o,
  input  logic [nbc_pkg::lg_ways-1:0] data_mem_way_o,
  input  logic [nbc_pkg::lg_sets+nbc_pkg::lg_block_words-1:0] data_mem_addr_o,
  input  logic [nbc_pkg::data_width-1:0] data_mem_data_o,
  input  logic stat_mem_pkt_v_o,
  input  logic [nbc_pkg::lg_ways-1:0] stat_mem_way_o,
  input  logic [nbc_pkg::lg_sets-1:0] stat_mem_index_o,
  input  nbc_pkg::stat_op_e stat_mem_opcode_o,
  input  logic block_loading_o,
  input  logic miss_v_o,
  input  logic miss_write_not_read_o,
  input  logic miss_block_load_o,
  input  logic [nbc_pkg::byte_sel_width-1:0] miss_size_op_o,
  input  logic [nbc_pkg::id_width-1:0] miss_id_o,
  input  logic [nbc_pkg::addr_width-1:0] miss_addr_o,
  input  logic [nbc_pkg::data_width-1:0] miss_data_o,
  input  logic mgmt_v_o,
  input  logic [nbc_pkg::ways-1:0] valid_tl_o,
  input  logic [nbc_pkg::ways-1:0] lock_tl_o,
  input  logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_tl_o,
  input  logic [nbc_pkg::lg_ways-1:0] tag_hit_way_o,
  input  logic tag_hit_found_o,
  output logic done_o,
  output int errors_o
);

  logic [67:0] trace_mem [32];
  logic [nbc_pkg::byte_sel_width-1:0] acc_size [32];
  int line_count;
  int acc_idx;
  int hit_words;
  int finished;
  int passed;
  bit test_err [32];
  int hit_q[$];
  int miss_q[$];
  int mgmt_q[$];

  // reference tag state built from the tag stores seen so far
  logic [nbc_pkg::ways-1:0] model_valid [nbc_pkg::sets];
  logic [nbc_pkg::ways-1:0] model_lock [nbc_pkg::sets];
  logic [nbc_pkg::tag_width-1:0] model_tag [nbc_pkg::sets][nbc_pkg::ways];

  initial begin
    for (int i = 0; i < 32; i++) begin
      trace_mem[i] = '1;
    end
    $readmemh("verification/nbc_trace.txt", trace_mem);
    line_count = 0;
    while (line_count < 32 && trace_mem[line_count][67:64] != 4'hf) begin
      line_count++;
    end
    for (int s = 0; s < nbc_pkg::sets; s++) begin
      model_valid[s] = '0;
    end
    done_o = 1'b0;
    errors_o = 0;
  end

  function automatic string request_name(input logic [3:0] op);
    case (op)
      4'd0: return "tag_store";
      4'd1: return "tag_read";
      4'd2: return "load";
      4'd3: return "store";
      default: return "block_load";
    endcase
  endfunction

  task automatic check_value(input int k, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("error test %0d %s %s: expected %0h actual %0h", k,
               request_name(trace_mem[k][67:64]), field, exp, act);
      errors_o++;
      test_err[k] = 1'b1;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("failure: %s", msg);
    errors_o++;
  endtask

  task automatic finish_test(input int k);
    $display("test %0d %s id %0h: %s", k, request_name(trace_mem[k][67:64]),
             trace_mem[k][59:56], test_err[k] ? "failed" : "ok");
    finished++;
    if (!test_err[k]) begin
      passed++;
    end
    if (finished == line_count) begin
      $display("tests %0d, passed %0d, errors %0d", finished, passed, errors_o);
      done_o = 1'b1;
    end
  endtask

  always @(posedge clk_i) begin : watch
    logic [67:0] t;
    logic [3:0] op;
    logic [3:0] idx;
    logic [1:0] word;
    int k;
    if (reset_i) begin
      acc_idx = 0;
      hit_words = 0;
      finished = 0;
      passed = 0;
    end else begin
      if (data_mem_pkt_v_o !== stat_mem_pkt_v_o) begin
        report_failure("data and status packet valids differ");
      end
      if (data_mem_pkt_v_o && !data_mem_ready_i) begin
        report_failure("data packet sent while data memory was not ready");
      end
      if (hit_words > 0 && data_mem_ready_i && !data_mem_pkt_v_o) begin
        report_failure("held hit was not sent although data memory was ready");
      end
      if (v_i && ready_o && hit_words > 0 && !(data_mem_pkt_v_o && hit_words == 1)) begin
        report_failure("new request accepted while a hit was still held");
      end
      if (data_mem_pkt_v_o) begin
        if (hit_q.size() == 0) begin
          report_failure("data packet with no hit request outstanding");
        end else begin
          k = hit_q[0];
          t = trace_mem[k];
          op = t[67:64];
          idx = t[47:44];
          word = (op == 4'd4) ? 2'(4 - hit_words) : t[43:42];
          check_value(k, "hit found", 1, tag_hit_found_o);
          check_value(k, "hit way", t[3:0], tag_hit_way_o);
          check_value(k, "way", t[3:0], data_mem_way_o);
          check_value(k, "data addr", {idx, word}, data_mem_addr_o);
          check_value(k, "byte sel", t[41:40], data_mem_byte_sel_o);
          check_value(k, "size op", acc_size[k], data_mem_size_op_o);
          check_value(k, "write_not_read", op == 4'd3, data_mem_write_not_read_o);
          if (op == 4'd3) begin
            check_value(k, "write data", t[39:8], data_mem_data_o);
          end
          check_value(k, "stat opcode", op == 4'd3, stat_mem_opcode_o);
          check_value(k, "stat index", idx, stat_mem_index_o);
          check_value(k, "stat way", t[3:0], stat_mem_way_o);
          if (op == 4'd4 && hit_words < 4) begin
            check_value(k, "block_loading", 1, block_loading_o);
          end
          hit_words--;
          if (hit_words == 0) begin
            void'(hit_q.pop_front());
            finish_test(k);
          end
        end
      end
      if (miss_v_o) begin
        if (miss_q.size() == 0) begin
          report_failure("miss queue output with no miss outstanding");
        end else begin
          k = miss_q.pop_front();
          t = trace_mem[k];
          check_value(k, "miss id", t[59:56], miss_id_o);
          check_value(k, "miss addr", t[55:40], miss_addr_o);
          check_value(k, "miss data", t[39:8], miss_data_o);
          check_value(k, "miss size op", acc_size[k], miss_size_op_o);
          check_value(k, "miss write_not_read", t[67:64] == 4'd3, miss_write_not_read_o);
          check_value(k, "miss block_load", t[67:64] == 4'd4, miss_block_load_o);
          finish_test(k);
        end
      end
      if (mgmt_v_o) begin
        if (mgmt_q.size() == 0) begin
          report_failure("management output with no management request outstanding");
        end else begin
          k = mgmt_q.pop_front();
          t = trace_mem[k];
          idx = t[47:44];
          if (t[67:64] == 4'd0) begin
            model_valid[idx][t[49:48]] = t[39];
            model_lock[idx][t[49:48]] = t[38];
            model_tag[idx][t[49:48]] = t[15:8];
          end else begin
            check_value(k, "valid bits", model_valid[idx], valid_tl_o);
            for (int w = 0; w < nbc_pkg::ways; w++) begin
              if (model_valid[idx][w]) begin
                check_value(k, "lock bit", model_lock[idx][w], lock_tl_o[w]);
                check_value(k, "tag", model_tag[idx][w], tag_tl_o[w]);
              end
            end
          end
          finish_test(k);
        end
      end
      if (v_i && ready_o) begin
        t = trace_mem[acc_idx];
        acc_size[acc_idx] = size_op_i;
        case (t[7:4])
          4'd0: mgmt_q.push_back(acc_idx);
          4'd1: begin
            hit_q.push_back(acc_idx);
            hit_words = (t[67:64] == 4'd4) ? nbc_pkg::block_words : 1;
          end
          default: miss_q.push_back(acc_idx);
        endcase
        acc_idx++;
      end
    end
  end

endmodule

// ==== verification/nbc_tb.sv ====
`timescale 1ns/100ps
// testbench for the cache tag-lookup front end
// drives requests from the trace, with a randomized data-memory ready
module nbc_tb;

  logic clk_i;
  logic reset_i;
  logic v_i;
  logic [nbc_pkg::id_width-1:0] id_i;
  logic [nbc_pkg::addr_width-1:0] addr_i;
  logic [nbc_pkg::data_width-1:0] data_i;
  logic ld_op_i;
  logic st_op_i;
  logic block_ld_op_i;
  logic mgmt_op_i;
  logic tagst_op_i;
  logic [nbc_pkg::byte_sel_width-1:0] size_op_i;
  logic ready_o;
  logic data_mem_pkt_v_o;
  logic data_mem_write_not_read_o;
  logic [nbc_pkg::byte_sel_width-1:0] data_mem_size_op_o;
  logic [nbc_pkg::byte_sel_width-1:0] data_mem_byte_sel_o;
  logic [nbc_pkg::lg_ways-1:0] data_mem_way_o;
  logic [nbc_pkg::lg_sets+nbc_pkg::lg_block_words-1:0] data_mem_addr_o;
  logic [nbc_pkg::data_width-1:0] data_mem_data_o;
  logic stat_mem_pkt_v_o;
  logic [nbc_pkg::lg_ways-1:0] stat_mem_way_o;
  logic [nbc_pkg::lg_sets-1:0] stat_mem_index_o;
  nbc_pkg::stat_op_e stat_mem_opcode_o;
  logic data_mem_ready_i;
  logic stat_mem_ready_i;
  logic block_loading_o;
  logic miss_v_o;
  logic miss_write_not_read_o;
  logic miss_block_load_o;
  logic [nbc_pkg::byte_sel_width-1:0] miss_size_op_o;
  logic [nbc_pkg::id_width-1:0] miss_id_o;
  logic [nbc_pkg::addr_width-1:0] miss_addr_o;
  logic [nbc_pkg::data_width-1:0] miss_data_o;
  logic miss_yumi_i;
  logic mgmt_v_o;
  logic [nbc_pkg::ways-1:0] valid_tl_o;
  logic [nbc_pkg::ways-1:0] lock_tl_o;
  logic [nbc_pkg::ways-1:0][nbc_pkg::tag_width-1:0] tag_tl_o;
  logic [nbc_pkg::lg_ways-1:0] tag_hit_way_o;
  logic tag_hit_found_o;
  logic mgmt_yumi_i;
  logic mhu_tag_v_i;
  nbc_pkg::tag_op_e mhu_tag_opcode_i;
  logic [nbc_pkg::lg_sets-1:0] mhu_tag_index_i;
  logic [nbc_pkg::lg_ways-1:0] mhu_tag_way_i;
  logic [nbc_pkg::data_width-1:0] mhu_tag_data_i;
  logic mhu_idle_i;
  logic recover_i;
  logic evict_v_i;
  logic [nbc_pkg::addr_width-1:0] evict_addr_i;

  logic chk_done;
  int chk_errors;
  logic [67:0] trace_mem [32];
  int line_count;
  int req_idx;
  int cycle_count;
  logic [15:0] lfsr;

  nbc_cache_tl_top i_dut (.*);

  nbc_checker i_checker (.*, .done_o(chk_done), .errors_o(chk_errors));

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    for (int i = 0; i < 32; i++) begin
      trace_mem[i] = '1;
    end
    $readmemh("verification/nbc_trace.txt", trace_mem);
    line_count = 0;
    while (line_count < 32 && trace_mem[line_count][67:64] != 4'hf) begin
      line_count++;
    end
    reset_i = 1'b1;
    v_i = 1'b0;
    id_i = '0;
    addr_i = '0;
    data_i = '0;
    ld_op_i = 1'b0;
    st_op_i = 1'b0;
    block_ld_op_i = 1'b0;
    mgmt_op_i = 1'b0;
    tagst_op_i = 1'b0;
    size_op_i = 2'd2;
    data_mem_ready_i = 1'b0;
    stat_mem_ready_i = 1'b1;
    miss_yumi_i = 1'b1;
    mgmt_yumi_i = 1'b1;
    mhu_tag_v_i = 1'b0;
    mhu_tag_opcode_i = nbc_pkg::tag_read;
    mhu_tag_index_i = '0;
    mhu_tag_way_i = '0;
    mhu_tag_data_i = '0;
    mhu_idle_i = 1'b1;
    recover_i = 1'b0;
    evict_v_i = 1'b0;
    evict_addr_i = '0;
    lfsr = 16'd12205;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    cycle_count = 0;
    while (!chk_done && cycle_count < 20 * line_count + 100) begin
      @(posedge clk_i);
      cycle_count++;
    end
    if (!chk_done) begin
      $display("timeout: run hung after %0d cycles", cycle_count);
    end
    if (chk_done && chk_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // present the next trace line once the current one is taken
  always @(posedge clk_i) begin : drive
    logic [67:0] t;
    int next;
    data_mem_ready_i <= lfsr[0];
    lfsr <= lfsr_step(lfsr);
    if (reset_i) begin
      req_idx <= 0;
    end else begin
      next = req_idx;
      if (v_i && ready_o) begin
        next = req_idx + 1;
        // eviction address holds from the lookup of the line that sets it
        if (trace_mem[req_idx][63:60] != 4'd0) begin
          evict_v_i <= 1'b1;
          evict_addr_i <= trace_mem[req_idx][55:40] & 16'hfff0;
        end
      end
      req_idx <= next;
      if (next < line_count) begin
        t = trace_mem[next];
        v_i <= 1'b1;
        id_i <= t[59:56];
        addr_i <= t[55:40];
        data_i <= t[39:8];
        tagst_op_i <= t[67:64] == 4'd0;
        mgmt_op_i <= t[67:64] <= 4'd1;
        ld_op_i <= t[67:64] == 4'd2;
        st_op_i <= t[67:64] == 4'd3;
        block_ld_op_i <= t[67:64] == 4'd4;
      end else begin
        v_i <= 1'b0;
      end
    end
  end

endmodule

// ==== list.f ====
design/nbc_pkg.sv
design/nbc_tag_mem.sv
design/nbc_tl_stage.sv
design/nbc_miss_fifo.sv
design/nbc_cache_tl_top.sv
verification/nbc_checker.sv
verification/nbc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module nbc_tb -f list.f -o nbc_sim &&
./obj_dir/nbc_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verification/nbc_trace.txt ====
// op_ev_id_addr_data_outcome_way
// op 0 tag store, 1 tag read, 2 load, 3 store, 4 block load; ev 1 sets eviction addr
// outcome 0 management, 1 hit, 2 miss; way is the expected hit way
0_0_1_0130_8000005A_0_0
0_0_2_0230_8000005A_0_0
0_0_3_0030_C0000011_0_0
1_0_4_0030_00000000_0_0
0_0_5_0350_80000077_0_0
1_0_6_0050_00000000_0_0
2_0_7_5A34_00000000_1_1
2_0_8_5A3C_00000000_1_1
2_0_9_1138_00000000_1_0
3_0_A_5A30_DEADBEEF_1_1
3_0_B_7758_12345678_1_3
2_0_C_2230_00000000_2_0
4_0_D_5A30_00000000_1_1
2_0_E_7754_00000000_1_3
2_1_F_7750_00000000_2_0
3_0_0_3330_CAFEF00D_2_0
4_0_1_1130_00000000_1_0
4_0_2_4440_00000000_2_0
0_0_3_0130_00000000_0_0
1_0_4_0030_00000000_0_0
2_0_5_5A34_00000000_1_2
